// ==== design/block_memory.sv ====
`default_nettype none

module block_memory (
	input  logic okClk,
	input  logic i_arst_n,
	mem_if.mem   mem,
	output logic o_calib_done
);

	host_pkg::word_t              ram [host_pkg::MEM_DEPTH];
	logic [host_pkg::CALIB_W-1:0] calib_cnt;

	// ------------------------------------------------------------
	// word storage, write at the edge, registered read
	// ------------------------------------------------------------
	always_ff @(posedge okClk) begin
		if (mem.wr_en)
			ram[mem.wr_addr] <= mem.wr_data;
		if (mem.rd_en)
			mem.rd_data <= ram[mem.rd_addr];
	end

	always_ff @(posedge okClk or negedge i_arst_n) begin
		if (!i_arst_n)
			mem.rd_valid <= 1'b0;
		else
			mem.rd_valid <= mem.rd_en;  // one cycle read latency
	end

	// ------------------------------------------------------------
	// start-up hold that stands in for controller calibration
	// ------------------------------------------------------------
	always_ff @(posedge okClk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			calib_cnt    <= '0;
			o_calib_done <= 1'b0;
		end else if (!o_calib_done) begin
			if (calib_cnt == host_pkg::CALIB_W'(host_pkg::CALIB_CYCLES - 1))
				o_calib_done <= 1'b1;  // sticky until the next reset
			else
				calib_cnt <= calib_cnt + 1'b1;
		end
	end

endmodule

`default_nettype wire

// ==== design/burst_counter.sv ====
`default_nettype none

module burst_counter (
	input  logic                okClk,
	input  logic                i_arst_n,
	input  logic                i_clear,
	input  logic                i_wr_step,      // one memory write
	input  logic                i_rd_step,      // one memory read
	input  logic                i_burst_start,  // load the beat counter
	input  logic                i_beat,
	output host_pkg::mem_addr_t o_wr_addr,
	output host_pkg::mem_addr_t o_rd_addr,
	output host_pkg::mem_cnt_t  o_stored,
	output logic                o_burst_last
);

	logic [host_pkg::BEAT_W-1:0] beats_left;  // beats after the current one

	assign o_burst_last = (beats_left == '0);

	// ------------------------------------------------------------
	// circular store pointers and occupancy
	// ------------------------------------------------------------
	always_ff @(posedge okClk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			o_wr_addr <= '0;
			o_rd_addr <= '0;
			o_stored  <= '0;
		end else if (i_clear) begin
			o_wr_addr <= '0;
			o_rd_addr <= '0;
			o_stored  <= '0;
		end else begin
			if (i_wr_step)
				o_wr_addr <= o_wr_addr + 1'b1;  // wraps at MEM_DEPTH
			if (i_rd_step)
				o_rd_addr <= o_rd_addr + 1'b1;
			case ({i_wr_step, i_rd_step})
				2'b10:   o_stored <= o_stored + 1'b1;
				2'b01:   o_stored <= o_stored - 1'b1;
				default: o_stored <= o_stored;
			endcase
		end
	end

	// beat counter of the burst in progress
	always_ff @(posedge okClk or negedge i_arst_n) begin
		if (!i_arst_n)
			beats_left <= '0;
		else if (i_clear)
			beats_left <= '0;
		else if (i_burst_start)
			beats_left <= host_pkg::BEAT_W'(host_pkg::BLOCK_SIZE - 1);
		else if (i_beat && !o_burst_last)
			beats_left <= beats_left - 1'b1;
	end

endmodule

`default_nettype wire

// ==== design/dma_fsm.sv ====
`default_nettype none

module dma_fsm (
	input  logic                okClk,
	input  logic                i_arst_n,
	input  logic                i_clear,
	input  logic                i_reads_en,
	input  logic                i_writes_en,
	input  logic                i_calib_done,
	fifo_rd_if.dma              in_fifo,
	mem_if.dma                  mem,
	input  host_pkg::fifo_cnt_t i_out_count,
	output logic                o_out_wr_en,
	output host_pkg::word_t     o_out_wr_data
);

	host_pkg::dma_state_t state;
	host_pkg::dma_state_t state_nxt;
	host_pkg::mem_cnt_t   stored;
	host_pkg::mem_addr_t  wr_addr;
	host_pkg::mem_addr_t  rd_addr;
	logic                 write_ok;
	logic                 read_ok;
	logic                 burst_start;
	logic                 burst_last;
	logic                 beat;

	// ------------------------------------------------------------
	// burst eligibility where only whole blocks move
	// ------------------------------------------------------------
	assign write_ok = i_calib_done && i_writes_en &&
		(in_fifo.count >= host_pkg::fifo_cnt_t'(host_pkg::BLOCK_SIZE)) &&
		(stored <= host_pkg::mem_cnt_t'(host_pkg::MEM_DEPTH - host_pkg::BLOCK_SIZE));

	assign read_ok = i_calib_done && i_reads_en &&
		(stored >= host_pkg::mem_cnt_t'(host_pkg::BLOCK_SIZE)) &&
		(i_out_count <= host_pkg::fifo_cnt_t'(host_pkg::FIFO_DEPTH - host_pkg::BLOCK_SIZE));

	always_comb begin
		state_nxt = state;
		case (state)
			host_pkg::IDLE: begin
				if (write_ok)
					state_nxt = host_pkg::WRITE_BURST;  // writes win a tie
				else if (read_ok)
					state_nxt = host_pkg::READ_BURST;
			end
			host_pkg::WRITE_BURST: begin
				if (burst_last)
					state_nxt = host_pkg::WRITE_DRAIN;
			end
			host_pkg::WRITE_DRAIN: begin
				if (!in_fifo.rd_valid)
					state_nxt = host_pkg::IDLE;  // last word is written at this edge
			end
			host_pkg::READ_BURST: begin
				if (burst_last)
					state_nxt = host_pkg::READ_DRAIN;
			end
			host_pkg::READ_DRAIN: begin
				if (!mem.rd_valid)
					state_nxt = host_pkg::IDLE;
			end
			default: state_nxt = host_pkg::IDLE;
		endcase
	end

	assign burst_start = (state == host_pkg::IDLE) && (write_ok || read_ok);
	assign beat        = (state == host_pkg::WRITE_BURST) || (state == host_pkg::READ_BURST);

	assign in_fifo.rd_en = (state == host_pkg::WRITE_BURST);  // one FIFO read per beat
	assign mem.rd_en     = (state == host_pkg::READ_BURST) && !i_clear;  // no word trails a flush
	assign mem.wr_addr   = wr_addr;
	assign mem.rd_addr   = rd_addr;

	// ------------------------------------------------------------
	// state and write strobes
	// ------------------------------------------------------------
	always_ff @(posedge okClk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			state       <= host_pkg::IDLE;
			mem.wr_en   <= 1'b0;
			o_out_wr_en <= 1'b0;
		end else if (i_clear) begin
			state       <= host_pkg::IDLE;
			mem.wr_en   <= 1'b0;
			o_out_wr_en <= 1'b0;
		end else begin
			state       <= state_nxt;
			mem.wr_en   <= in_fifo.rd_valid;  // FIFO word lands in memory next cycle
			o_out_wr_en <= mem.rd_valid;      // memory word lands in pipe-out next cycle
		end
	end

	always_ff @(posedge okClk) begin
		mem.wr_data   <= in_fifo.rd_data;
		o_out_wr_data <= mem.rd_data;
	end

	burst_counter u_burst_counter (
		.okClk         (okClk),
		.i_arst_n      (i_arst_n),
		.i_clear       (i_clear),
		.i_wr_step     (mem.wr_en),
		.i_rd_step     (mem.rd_en),
		.i_burst_start (burst_start),
		.i_beat        (beat),
		.o_wr_addr     (wr_addr),
		.o_rd_addr     (rd_addr),
		.o_stored      (stored),
		.o_burst_last  (burst_last)
	);

endmodule

`default_nettype wire

// ==== design/dma_ifs.sv ====
`default_nettype none

// ------------------------------------------------------------
// read side of the pipe-in FIFO as seen by the DMA
// ------------------------------------------------------------
interface fifo_rd_if (input logic okClk);

	logic               rd_en;     // only while count is non-zero
	host_pkg::word_t    rd_data;   // one cycle after rd_en
	logic               rd_valid;
	host_pkg::fifo_cnt_t count;

	modport fifo (
		input  okClk,
		input  rd_en,
		output rd_data,
		output rd_valid,
		output count
	);

	modport dma (
		input  okClk,
		output rd_en,
		input  rd_data,
		input  rd_valid,
		input  count
	);

endinterface

// ------------------------------------------------------------
// single port of the block memory, one write and one read path
// ------------------------------------------------------------
interface mem_if (input logic okClk);

	logic                wr_en;
	host_pkg::mem_addr_t wr_addr;
	host_pkg::word_t     wr_data;
	logic                rd_en;
	host_pkg::mem_addr_t rd_addr;
	host_pkg::word_t     rd_data;   // valid the cycle after rd_en
	logic                rd_valid;

	modport mem (
		input  okClk,
		input  wr_en, wr_addr, wr_data,
		input  rd_en, rd_addr,
		output rd_data, rd_valid
	);

	modport dma (
		input  okClk,
		output wr_en, wr_addr, wr_data,
		output rd_en, rd_addr,
		input  rd_data, rd_valid
	);

endinterface

`default_nettype wire

// ==== design/host_pkg.sv ====
`default_nettype none

package host_pkg;

	// ------------------------------------------------------------
	// sizes shared by the pipe FIFOs, the DMA and the memory
	// ------------------------------------------------------------
	localparam int WORD_W          = 32;
	localparam int BLOCK_SIZE      = 16;  // words per burst and per throttle block
	localparam int FIFO_DEPTH      = 64;
	localparam int FIFO_CNT_W      = 7;   // holds 0 to FIFO_DEPTH
	localparam int FIFO_PTR_W      = $clog2(FIFO_DEPTH);
	localparam int BUFFER_HEADROOM = 4;   // margin for host latency on the pipe-in side

	localparam int MEM_DEPTH       = 256;
	localparam int MEM_ADDR_W      = 8;
	localparam int MEM_CNT_W       = 9;   // holds 0 to MEM_DEPTH
	localparam int BEAT_W          = $clog2(BLOCK_SIZE);

	localparam int CALIB_CYCLES    = 8;   // start-up hold before the memory reports ready
	localparam int CALIB_W         = $clog2(CALIB_CYCLES);

	typedef logic [WORD_W-1:0]     word_t;
	typedef logic [FIFO_CNT_W-1:0] fifo_cnt_t;
	typedef logic [MEM_ADDR_W-1:0] mem_addr_t;
	typedef logic [MEM_CNT_W-1:0]  mem_cnt_t;

	typedef enum logic [2:0] {
		IDLE,
		WRITE_BURST,  // pipe-in FIFO to memory
		WRITE_DRAIN,
		READ_BURST,   // memory to pipe-out FIFO
		READ_DRAIN
	} dma_state_t;

endpackage

`default_nettype wire

// ==== design/pipe_dma_top.sv ====
`default_nettype none

module pipe_dma_top (
	input  logic            okClk,
	input  logic            i_arst_n,
	input  logic            i_writes_en,      // control wire bit 1
	input  logic            i_reads_en,       // control wire bit 0
	input  logic            i_fifo_reset,     // control wire bit 2
	input  logic            i_pipe_in_write,
	input  host_pkg::word_t i_pipe_in_data,
	output logic            o_pipe_in_ready,
	input  logic            i_pipe_out_read,
	output host_pkg::word_t o_pipe_out_data,
	output logic            o_pipe_out_valid,
	output logic            o_pipe_out_ready,
	output logic [5:0]      o_led
);

	host_pkg::fifo_cnt_t out_count;
	host_pkg::word_t     out_wr_data;
	logic                out_wr_en;
	logic                in_full;
	logic                in_empty;
	logic                out_full;
	logic                out_empty;
	logic                calib_done;

	fifo_rd_if in_fifo (.okClk(okClk));
	mem_if     mem_bus (.okClk(okClk));

	// ------------------------------------------------------------
	// host side FIFOs
	// ------------------------------------------------------------
	pipe_fifo u_pipe_in (
		.i_clk_ok         (okClk),
		.i_arst_n         (i_arst_n),
		.i_clear          (i_fifo_reset),
		.i_wr_en          (i_pipe_in_write),
		.i_wr_data        (i_pipe_in_data),
		.i_rd_en          (in_fifo.rd_en),
		.o_rd_data        (in_fifo.rd_data),
		.o_rd_valid       (in_fifo.rd_valid),
		.o_count          (in_fifo.count),
		.o_full           (in_full),
		.o_empty          (in_empty),
		.o_room_for_block (o_pipe_in_ready),
		.o_block_avail    ()
	);

	pipe_fifo u_pipe_out (
		.i_clk_ok         (okClk),
		.i_arst_n         (i_arst_n),
		.i_clear          (i_fifo_reset),
		.i_wr_en          (out_wr_en),
		.i_wr_data        (out_wr_data),
		.i_rd_en          (i_pipe_out_read),
		.o_rd_data        (o_pipe_out_data),
		.o_rd_valid       (o_pipe_out_valid),
		.o_count          (out_count),
		.o_full           (out_full),
		.o_empty          (out_empty),
		.o_room_for_block (),
		.o_block_avail    (o_pipe_out_ready)
	);

	// ------------------------------------------------------------
	// block mover and the memory it feeds
	// ------------------------------------------------------------
	dma_fsm u_dma_fsm (
		.okClk         (okClk),
		.i_arst_n      (i_arst_n),
		.i_clear       (i_fifo_reset),
		.i_reads_en    (i_reads_en),
		.i_writes_en   (i_writes_en),
		.i_calib_done  (calib_done),
		.in_fifo       (in_fifo.dma),
		.mem           (mem_bus.dma),
		.i_out_count   (out_count),
		.o_out_wr_en   (out_wr_en),
		.o_out_wr_data (out_wr_data)
	);

	block_memory u_block_memory (
		.okClk        (okClk),
		.i_arst_n     (i_arst_n),
		.mem          (mem_bus.mem),
		.o_calib_done (calib_done)
	);

	// status LEDs light on a low level
	assign o_led = ~{in_full, in_empty, out_full, out_empty, i_writes_en, calib_done};

endmodule

`default_nettype wire

// ==== design/pipe_fifo.sv ====
`default_nettype none

module pipe_fifo (
	input  logic                i_clk_ok,
	input  logic                i_arst_n,
	input  logic                i_clear,           // synchronous flush
	input  logic                i_wr_en,
	input  host_pkg::word_t     i_wr_data,
	input  logic                i_rd_en,
	output host_pkg::word_t     o_rd_data,
	output logic                o_rd_valid,
	output host_pkg::fifo_cnt_t o_count,
	output logic                o_full,
	output logic                o_empty,
	output logic                o_room_for_block,  // pipe-in throttle
	output logic                o_block_avail      // pipe-out throttle
);

	host_pkg::word_t                 fifo_mem [host_pkg::FIFO_DEPTH];
	logic [host_pkg::FIFO_PTR_W-1:0] wr_ptr;
	logic [host_pkg::FIFO_PTR_W-1:0] rd_ptr;
	logic                            do_wr;
	logic                            do_rd;

	assign o_full  = (o_count == host_pkg::fifo_cnt_t'(host_pkg::FIFO_DEPTH));
	assign o_empty = (o_count == '0);
	assign do_wr   = i_wr_en && !o_full;   // write when full is dropped
	assign do_rd   = i_rd_en && !o_empty;  // read when empty is dropped

	// ------------------------------------------------------------
	// pointers and fill count
	// ------------------------------------------------------------
	always_ff @(posedge i_clk_ok or negedge i_arst_n) begin
		if (!i_arst_n) begin
			wr_ptr     <= '0;
			rd_ptr     <= '0;
			o_count    <= '0;
			o_rd_valid <= 1'b0;
		end else if (i_clear) begin
			wr_ptr     <= '0;
			rd_ptr     <= '0;
			o_count    <= '0;
			o_rd_valid <= 1'b0;
		end else begin
			o_rd_valid <= do_rd;
			if (do_wr)
				wr_ptr <= wr_ptr + 1'b1;  // wraps at FIFO_DEPTH
			if (do_rd)
				rd_ptr <= rd_ptr + 1'b1;
			case ({do_wr, do_rd})
				2'b10:   o_count <= o_count + 1'b1;
				2'b01:   o_count <= o_count - 1'b1;
				default: o_count <= o_count;
			endcase
		end
	end

	// storage and registered read data
	always_ff @(posedge i_clk_ok) begin
		if (do_wr)
			fifo_mem[wr_ptr] <= i_wr_data;
		if (do_rd)
			o_rd_data <= fifo_mem[rd_ptr];
	end

	// ------------------------------------------------------------
	// block throttle flags, one cycle behind the count
	// ------------------------------------------------------------
	always_ff @(posedge i_clk_ok or negedge i_arst_n) begin
		if (!i_arst_n) begin
			o_room_for_block <= 1'b0;
			o_block_avail    <= 1'b0;
		end else begin
			o_room_for_block <= (o_count <= host_pkg::fifo_cnt_t'(host_pkg::FIFO_DEPTH -
				host_pkg::BUFFER_HEADROOM - host_pkg::BLOCK_SIZE));
			o_block_avail    <= (o_count >= host_pkg::fifo_cnt_t'(host_pkg::BLOCK_SIZE));
		end
	end

endmodule

`default_nettype wire

// ==== filelist.f ====
design/host_pkg.sv
design/dma_ifs.sv
design/pipe_fifo.sv
design/block_memory.sv
design/burst_counter.sv
design/dma_fsm.sv
design/pipe_dma_top.sv
test/tb_pipe_dma_properties.sv
test/tb_pipe_dma.sv

// ==== test/tb_pipe_dma.sv ====
`default_nettype none

module tb_pipe_dma;

	typedef struct packed {
		logic [7:0] n_push;   // words pushed in this row
		logic       wr_en;
		logic       rd_en;
		logic       clr;      // pulse i_fifo_reset first
		logic [7:0] n_pop;    // whole blocks only
		logic       out_rdy;  // final o_pipe_out_ready level
	} row_t;

	logic            okClk = 1'b0;
	logic            i_arst_n;
	logic            i_writes_en;
	logic            i_reads_en;
	logic            i_fifo_reset;
	logic            i_pipe_in_write;
	host_pkg::word_t i_pipe_in_data;
	logic            o_pipe_in_ready;
	logic            i_pipe_out_read;
	host_pkg::word_t o_pipe_out_data;
	logic            o_pipe_out_valid;
	logic            o_pipe_out_ready;
	logic [5:0]      o_led;

	logic [31:0]     lfsr = 32'hd9bd07c0;
	host_pkg::word_t expected [$];
	int              in_level;  // words left in the pipe-in FIFO
	row_t            rows [9];

	always #10 okClk = ~okClk;

	pipe_dma_top u_dut (.*);

	// ------------------------------------------------------------
	// error reporting and compare tasks
	// ------------------------------------------------------------
	task automatic stop_run(input string line);
		$display("%s", line);
		$display("Finished with errors");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic check_word(input string what, input host_pkg::word_t got,
		input host_pkg::word_t exp);
		if (got !== exp)
			stop_run($sformatf("[FAIL] %0t: %s is %h, expected %h", $time, what, got, exp));
	endtask

	task automatic check_flag(input string what, input logic got, input logic exp);
		if (got !== exp)
			stop_run($sformatf("[FAIL] %0t: %s is %b, expected %b", $time, what, got, exp));
	endtask

	// counts one waited cycle and gives up after 2000
	task automatic count_cycle(inout int cycles, input string what);
		cycles++;
		if (cycles > 2000)
			stop_run($sformatf("timeout at %0t while waiting for %s", $time, what));
	endtask

	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		if (s[0])
			return (s >> 1) ^ 32'h80200003;  // taps 32 22 2 1
		return s >> 1;
	endfunction

	function automatic host_pkg::word_t next_word();
		host_pkg::word_t w;
		w = '0;
		for (int b = 0; b < host_pkg::WORD_W; b++) begin
			lfsr = lfsr_step(lfsr);
			w    = {w[host_pkg::WORD_W-2:0], lfsr[0]};
		end
		return w;
	endfunction

	task automatic wait_in_ready();
		int cycles;
		cycles = 0;
		@(negedge okClk);
		while (!o_pipe_in_ready) begin
			count_cycle(cycles, "o_pipe_in_ready");
			@(negedge okClk);
		end
	endtask

	task automatic wait_out_ready();
		int cycles;
		cycles = 0;
		@(negedge okClk);
		while (!o_pipe_out_ready) begin
			count_cycle(cycles, "o_pipe_out_ready");
			@(negedge okClk);
		end
	endtask

	// ------------------------------------------------------------
	// host side drivers
	// ------------------------------------------------------------
	task automatic push_words(input int n);
		host_pkg::word_t w;
		for (int i = 0; i < n; i++) begin
			if (i % host_pkg::BLOCK_SIZE == 0) begin
				@(posedge okClk);
				i_pipe_in_write <= 1'b0;
				repeat (2) @(posedge okClk);  // throttle flag trails the count
				wait_in_ready();
			end
			w = next_word();
			expected.push_back(w);
			@(posedge okClk);
			i_pipe_in_write <= 1'b1;
			i_pipe_in_data  <= w;
		end
		@(posedge okClk);
		i_pipe_in_write <= 1'b0;
		in_level += n;
	endtask

	task automatic pop_block();
		int sent;
		int got;
		int cycles;
		sent   = 0;
		got    = 0;
		cycles = 0;
		wait_out_ready();
		while (got < host_pkg::BLOCK_SIZE) begin
			@(posedge okClk);
			i_pipe_out_read <= (sent < host_pkg::BLOCK_SIZE);
			if (sent < host_pkg::BLOCK_SIZE)
				sent++;
			@(negedge okClk);
			if (o_pipe_out_valid) begin
				if (expected.size() == 0)
					stop_run("pipe-out returned a word that was never pushed");
				check_word("o_pipe_out_data", o_pipe_out_data, expected.pop_front());
				got++;
			end
			count_cycle(cycles, "o_pipe_out_valid");
		end
		@(posedge okClk);
		i_pipe_out_read <= 1'b0;
	endtask

	task automatic hold_out_low();
		repeat (100) begin
			@(negedge okClk);
			check_flag("o_pipe_out_ready", o_pipe_out_ready, 1'b0);
		end
	endtask

	initial begin
		row_t r;
		i_arst_n        = 1'b0;
		i_writes_en     = 1'b0;
		i_reads_en      = 1'b0;
		i_fifo_reset    = 1'b0;
		i_pipe_in_write = 1'b0;
		i_pipe_in_data  = '0;
		i_pipe_out_read = 1'b0;
		in_level        = 0;
		rows[0] = '{8'd48, 1'b1, 1'b1, 1'b0, 8'd48, 1'b0};  // three blocks straight through
		rows[1] = '{8'd32, 1'b1, 1'b0, 1'b0, 8'd0,  1'b0};  // park two blocks in memory
		rows[2] = '{8'd0,  1'b1, 1'b1, 1'b0, 8'd32, 1'b0};
		rows[3] = '{8'd10, 1'b1, 1'b1, 1'b0, 8'd0,  1'b0};  // partial block stays put
		rows[4] = '{8'd6,  1'b1, 1'b1, 1'b0, 8'd0,  1'b1};
		rows[5] = '{8'd48, 1'b0, 1'b1, 1'b0, 8'd16, 1'b0};  // fill pipe-in past the throttle
		rows[6] = '{8'd0,  1'b1, 1'b1, 1'b0, 8'd48, 1'b0};
		rows[7] = '{8'd21, 1'b1, 1'b0, 1'b0, 8'd0,  1'b0};  // stale words for the flush
		rows[8] = '{8'd16, 1'b1, 1'b1, 1'b1, 8'd16, 1'b0};

		repeat (10) @(posedge okClk);
		i_arst_n <= 1'b1;

		// ------------------------------------------------------------
		// levels right after reset
		// ------------------------------------------------------------
		@(negedge okClk);
		check_flag("o_pipe_out_valid", o_pipe_out_valid, 1'b0);
		check_flag("o_pipe_out_ready", o_pipe_out_ready, 1'b0);
		check_flag("o_pipe_in_ready", o_pipe_in_ready, 1'b0);
		check_flag("LED calibration done", o_led[0], 1'b1);
		check_flag("LED pipe-in full", o_led[5], 1'b1);
		check_flag("LED pipe-out full", o_led[3], 1'b1);
		@(negedge okClk);
		check_flag("o_pipe_in_ready", o_pipe_in_ready, 1'b1);
		check_flag("LED pipe-in empty", o_led[4], 1'b0);
		check_flag("LED pipe-out empty", o_led[2], 1'b0);
		repeat (host_pkg::CALIB_CYCLES - 2) @(negedge okClk);
		check_flag("LED calibration done", o_led[0], 1'b1);
		@(negedge okClk);
		check_flag("LED calibration done", o_led[0], 1'b0);

		foreach (rows[k]) begin
			r = rows[k];
			if (r.clr) begin
				@(posedge okClk);
				i_fifo_reset <= 1'b1;
				@(posedge okClk);
				i_fifo_reset <= 1'b0;
				@(negedge okClk);
				check_flag("LED pipe-in empty", o_led[4], 1'b0);
				check_flag("LED pipe-out empty", o_led[2], 1'b0);
				expected.delete();  // flushed words never come back
				in_level = 0;
			end
			@(posedge okClk);
			i_writes_en <= r.wr_en;
			i_reads_en  <= r.rd_en;
			@(negedge okClk);
			check_flag("LED writes enabled", o_led[1], !r.wr_en);
			push_words(r.n_push);
			for (int b = 0; b < r.n_pop; b += host_pkg::BLOCK_SIZE)
				pop_block();
			if (r.out_rdy)
				wait_out_ready();
			else
				hold_out_low();
			if (r.wr_en) begin
				wait_in_ready();  // whole blocks drain while a partial one stays
				in_level = in_level % host_pkg::BLOCK_SIZE;
			end else begin
				check_flag("o_pipe_in_ready", o_pipe_in_ready, in_level <=
					host_pkg::FIFO_DEPTH - host_pkg::BUFFER_HEADROOM - host_pkg::BLOCK_SIZE);
			end
		end
		check_flag("every pushed word returned", expected.size() == 0, 1'b1);

		if (u_dut.u_dma_fsm.u_props.assert_fails == 0) begin
			$display("Finished with no errors");
			$finish;
		end else begin
			stop_run("bound assertions failed during the run");
		end
	end

endmodule

`default_nettype wire

// ==== test/tb_pipe_dma_properties.sv ====
`default_nettype none

module tb_pipe_dma_properties (
	input logic                 okClk,
	input logic                 i_arst_n,
	input logic                 i_clear,
	input logic                 i_calib_done,
	input host_pkg::dma_state_t i_state,
	input logic                 i_fifo_rd_en,
	input host_pkg::fifo_cnt_t  i_fifo_count,
	input logic                 i_mem_rd_en,
	input logic                 i_out_wr_en
);

	int unsigned assert_fails = 0;  // failed assertions so far

	// ------------------------------------------------------------
	// pipe-in FIFO read side and burst start
	// ------------------------------------------------------------
	a_no_empty_read: assert property (@(posedge okClk) disable iff (!i_arst_n)
		i_fifo_rd_en |-> (i_fifo_count != '0))
	else begin
		$error("pipe-in FIFO read while its count is zero");
		assert_fails++;
	end

	a_calib_first: assert property (@(posedge okClk) disable iff (!i_arst_n)
		(i_state != host_pkg::IDLE) |-> i_calib_done)
	else begin
		$error("DMA burst running before calibration is done");
		assert_fails++;
	end

	// memory word lands in the pipe-out FIFO one cycle after it returns
	a_out_after_read: assert property (@(posedge okClk) disable iff (!i_arst_n || i_clear)
		i_mem_rd_en |-> ##2 i_out_wr_en)
	else begin
		$error("returned memory word not written to the pipe-out FIFO");
		assert_fails++;
	end

	a_out_has_read: assert property (@(posedge okClk) disable iff (!i_arst_n || i_clear)
		i_out_wr_en |-> $past(i_mem_rd_en, 2))
	else begin
		$error("pipe-out FIFO write without a memory read before it");
		assert_fails++;
	end

endmodule

bind dma_fsm tb_pipe_dma_properties u_props (
	.okClk          (okClk),
	.i_arst_n       (i_arst_n),
	.i_clear        (i_clear),
	.i_calib_done   (i_calib_done),
	.i_state        (state),
	.i_fifo_rd_en   (in_fifo.rd_en),
	.i_fifo_count   (in_fifo.count),
	.i_mem_rd_en    (mem.rd_en),
	.i_out_wr_en    (o_out_wr_en)
);

`default_nettype wire
